//--- Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= exu_core_tb
FILELIST  ?= exu_core.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^NO ERRORS$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- exu_core.f
+incdir+include
source/exu_pkg.sv
source/exu_operand_sel.sv
source/exu_alu_ctl.sv
source/exu_ghr.sv
source/exu_core.sv
sim/exu_core_tb.sv

//--- include/exu_defs.svh
// Execute stage widths, sizes and opcode count shared by package and RTL
`ifndef EXU_DEFS_SVH
`define EXU_DEFS_SVH

// Datapath word
`define EXU_XLEN        32

// PC kept in halfwords, bit 0 dropped
`define EXU_PC_W        (`EXU_XLEN-1)

// Global branch history depth
`define EXU_GHR_SIZE    8

// Branch offset in halfwords
`define EXU_BR_IMM_W    12

// result_r, lsu_m, result_x, nonblock
`define EXU_NUM_BYPASS  4

// Defined ALU and branch operations
`define EXU_NUM_OPS     12
`define EXU_OP_W        $clog2(`EXU_NUM_OPS)

`endif

//--- sim/exu_core_patterns.mem
// Even: v op pred pc imm src1 src2 rs1 rs2 immed result_r lsu_m nonblock flush_lower path
// Odd: next-cycle result_valid result pc mp_valid ataken target ghr flush path ghr_d
1_0_0_00000100_000_20_20_00000005_00000003_00000000_00000000_00000000_00000000_0_00000000
1_00000008_00000100_0_0_00000000_00_0_00000000_00
1_1_0_00000102_000_20_20_00000003_00000005_00000000_00000000_00000000_00000000_0_00000000
1_fffffffe_00000102_0_0_00000000_00_0_00000000_00
1_2_0_00000104_000_20_20_f0f0f0f0_ff00ff00_00000000_00000000_00000000_00000000_0_00000000
1_f000f000_00000104_0_0_00000000_00_0_00000000_00
1_3_0_00000106_000_20_20_0f0f0000_000000f0_00000000_00000000_00000000_00000000_0_00000000
1_0f0f00f0_00000106_0_0_00000000_00_0_00000000_00
1_4_0_00000108_000_20_20_aaaaaaaa_ffff0000_00000000_00000000_00000000_00000000_0_00000000
1_5555aaaa_00000108_0_0_00000000_00_0_00000000_00
1_5_0_0000010a_000_20_20_ffffffff_00000001_00000000_00000000_00000000_00000000_0_00000000
1_00000001_0000010a_0_0_00000000_00_0_00000000_00
1_6_0_0000010c_000_20_20_ffffffff_00000001_00000000_00000000_00000000_00000000_0_00000000
1_00000000_0000010c_0_0_00000000_00_0_00000000_00
1_0_0_0000010e_000_20_01_00001000_deadbeef_00000234_00000000_00000000_00000000_0_00000000
1_00001234_0000010e_0_0_00000000_00_0_00000000_00
1_0_0_00000200_000_01_01_00000bad_00000bad_00000010_00000000_00000000_00000000_0_00000000
1_00000410_00000200_0_0_00000000_00_0_00000000_00
1_7_0_00000300_000_00_00_00000000_00000000_00000000_00000000_00000000_00000000_0_00000000
1_00000604_00000300_0_0_00000000_00_0_00000000_00
1_0_0_00000302_000_22_20_0000dead_00000001_00000000_00000100_00000000_00000000_0_00000000
1_00000101_00000302_0_0_00000000_00_0_00000000_00
1_0_0_00000304_000_20_24_00000010_0000ffff_00000000_00000000_00000020_00000000_0_00000000
1_00000030_00000304_0_0_00000000_00_0_00000000_00
1_0_0_00000306_000_30_20_00000000_00000007_00000000_00000000_00000000_00000700_0_00000000
1_00000707_00000306_0_0_00000000_00_0_00000000_00
1_0_0_00000308_000_28_20_0000beef_00000001_00000000_00000000_00000000_00000000_0_00000000
1_00000708_00000308_0_0_00000000_00_0_00000000_00
1_1_0_0000030a_000_28_20_00000000_00000008_00000000_00000000_00000000_00000000_0_00000000
1_00000700_0000030a_0_0_00000000_00_0_00000000_00
1_8_1_00000400_010_20_20_00000005_00000005_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_0_00000000_01
1_9_0_00000402_010_20_20_00000005_00000005_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_0_00000000_02
1_a_0_00000500_020_20_20_ffffffff_00000001_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_1_1_00000520_05_1_00000520_04
1_8_1_00000600_004_20_20_00000001_00000002_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_0_00000000_05
1_b_1_00000700_040_20_20_00000001_00000002_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_1_0_00000702_0a_1_00000702_0b
1_0_0_00000800_000_20_20_00000001_00000001_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_0_00000000_0a
1_9_0_00000900_008_20_20_00000001_00000002_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_1_00001234_14
1_8_1_00000a00_002_20_20_00000003_00000003_00000000_00000000_00000000_00000000_1_00001234
0_00000000_00000000_0_0_00000000_00_0_00000000_0a
0_0_0_00000000_000_00_00_00000000_00000000_00000000_00000000_00000000_00000000_0_00000000
0_00000000_00000000_0_0_00000000_00_0_00000000_0a
1_0_0_00000b00_000_20_20_12345678_11111111_00000000_00000000_00000000_00000000_0_00000000
1_23456789_00000b00_0_0_00000000_00_0_00000000_0a

//--- sim/exu_core_tb.sv
// Execute stage testbench replaying stimulus and expected results from a pattern file
`include "exu_defs.svh"

module exu_core_tb;

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_TESTS    = 25;
   localparam int RESET_CYCLES = 5;
   localparam int LINE_W       = 300;
   localparam int CYCLE_LIMIT  = NUM_TESTS + RESET_CYCLES + 20;
   localparam int RESET_STIM   = 18;  // Mispredicting branch, predicted taken

   logic                       clk;
   logic                       i_reset;
   exu_pkg::exu_d_pkt_t        i_d_pkt;
   logic [`EXU_XLEN-1:0]       i_gpr_rs1;
   logic [`EXU_XLEN-1:0]       i_gpr_rs2;
   logic [`EXU_XLEN-1:0]       i_immed;
   exu_pkg::exu_bypass_t       i_bypass;
   logic                       i_flush_lower_r;
   logic [`EXU_PC_W-1:0]       i_flush_path_r;
   exu_pkg::exu_x_out_t        o_x_out;
   exu_pkg::exu_mp_pkt_t       o_mp_pkt;
   logic [`EXU_GHR_SIZE-1:0]   o_ghr_d;
   logic                       o_flush_final;
   logic [`EXU_PC_W-1:0]       o_flush_path_final;

   logic [LINE_W-1:0]          patterns [0:2*NUM_TESTS-1];  // Stimulus then expected
   int                         cycle_count;

   exu_core i_exu_core (
      .clk                (clk),
      .i_reset            (i_reset),
      .i_d_pkt            (i_d_pkt),
      .i_gpr_rs1          (i_gpr_rs1),
      .i_gpr_rs2          (i_gpr_rs2),
      .i_immed            (i_immed),
      .i_bypass           (i_bypass),
      .i_flush_lower_r    (i_flush_lower_r),
      .i_flush_path_r     (i_flush_path_r),
      .o_x_out            (o_x_out),
      .o_mp_pkt           (o_mp_pkt),
      .o_ghr_d            (o_ghr_d),
      .o_flush_final      (o_flush_final),
      .o_flush_path_final (o_flush_path_final)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #4 clk = ~clk;  // 8 ns period
      end
   end

   task automatic report_failure();
      $display("ERRORS FOUND");
      $fatal(1, "DUT output did not match the pattern file");
   endtask

   task automatic check_x_out(input string name, input exu_pkg::exu_x_out_t exp,
                              input exu_pkg::exu_x_out_t act);
      if (act !== exp) begin
         $display("[ERROR] %s x_out expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_mp(input string name, input exu_pkg::exu_mp_pkt_t exp,
                           input exu_pkg::exu_mp_pkt_t act);
      if (act !== exp) begin
         $display("[ERROR] %s mp_pkt expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   task automatic check_flush(input string name, input logic exp_flush,
                              input logic [`EXU_PC_W-1:0] exp_path, input logic act_flush,
                              input logic [`EXU_PC_W-1:0] act_path);
      if (act_flush !== exp_flush || act_path !== exp_path) begin
         $display("[ERROR] %s flush expected %b/%h actual %b/%h", name, exp_flush, exp_path,
                  act_flush, act_path);
         report_failure();
      end
   endtask

   task automatic check_ghr(input string name, input logic [`EXU_GHR_SIZE-1:0] exp,
                            input logic [`EXU_GHR_SIZE-1:0] act);
      if (act !== exp) begin
         $display("[ERROR] %s ghr_d expected %h actual %h", name, exp, act);
         report_failure();
      end
   endtask

   // Field offsets follow the column order in the pattern file
   task automatic apply_stimulus(input logic [LINE_W-1:0] s);
      i_d_pkt.valid      = s[296];
      i_d_pkt.op         = exu_pkg::exu_op_e'(s[295:292]);
      i_d_pkt.pred_taken = s[288];
      i_d_pkt.pc         = s[286:256];
      i_d_pkt.br_immed   = s[255:244];
      i_d_pkt.src1       = s[241:236];
      i_d_pkt.src2       = s[233:228];
      i_gpr_rs1          = s[227:196];
      i_gpr_rs2          = s[195:164];
      i_immed            = s[163:132];
      i_bypass.result_r  = s[131:100];
      i_bypass.lsu_m     = s[99:68];
      i_bypass.nonblock  = s[67:36];
      i_flush_lower_r    = s[32];
      i_flush_path_r     = s[30:0];
   endtask

   task automatic check_outputs(input string name, input logic [LINE_W-1:0] e);
      exu_pkg::exu_x_out_t  exp_x;
      exu_pkg::exu_mp_pkt_t exp_mp;
      exp_x.result_valid = e[156];
      exp_x.result       = e[155:124];
      exp_x.pc           = e[122:92];
      exp_mp.valid       = e[88];
      exp_mp.ataken      = e[84];
      exp_mp.target      = e[82:52];
      exp_mp.ghr         = e[51:44];
      check_x_out(name, exp_x, o_x_out);
      check_mp(name, exp_mp, o_mp_pkt);
      check_flush(name, e[40], e[38:8], o_flush_final, o_flush_path_final);
      check_ghr(name, e[7:0], o_ghr_d);
   endtask

   // Bounds the run in case the replay loop stalls
   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles without finishing the patterns", cycle_count);
         $display("ERRORS FOUND");
         $fatal(1, "Simulation timed out");
      end
   end

   initial begin
      string name;
      cycle_count = 0;
      i_reset     = 1'b1;
      $readmemh("sim/exu_core_patterns.mem", patterns);
      apply_stimulus(patterns[2*RESET_STIM]);  // Reset has to hold this branch off
      repeat (RESET_CYCLES) @(posedge clk);
      for (int k = 0; k < NUM_TESTS; k++) begin
         #1;
         i_reset = 1'b0;
         apply_stimulus(patterns[2*k]);
         #6;
         if (k == 0) begin
            check_outputs("reset", '0);  // Everything idle out of reset
         end else begin
            name = $sformatf("pattern %0d", k - 1);
            check_outputs(name, patterns[2*k-1]);
         end
         @(posedge clk);
      end
      #1;
      apply_stimulus('0);  // Idle cycle drains the last instruction
      #6;
      name = $sformatf("pattern %0d", NUM_TESTS - 1);
      check_outputs(name, patterns[2*NUM_TESTS-1]);
      $display("NO ERRORS");
      $finish;
   end

endmodule

//--- source/exu_alu_ctl.sv
// X-stage ALU with branch compare, mispredict detection and redirect target
`include "exu_defs.svh"

module exu_alu_ctl (
   input  logic                  clk,
   input  logic                  i_reset,
   input  exu_pkg::exu_d_pkt_t   i_d_pkt,       // Instruction in D
   input  logic [`EXU_XLEN-1:0]  i_rs1,         // Selected operands in D
   input  logic [`EXU_XLEN-1:0]  i_rs2,
   input  logic                  i_kill_d,      // Drop the D instruction
   output exu_pkg::exu_x_out_t   o_x_out,
   output logic                  o_br_valid_x,  // Branch resolving in X
   output logic                  o_br_taken_x,  // Actual direction
   output logic                  o_misp_x,      // Direction differs from prediction
   output logic [`EXU_PC_W-1:0]  o_target_x     // Correct next PC
);

   logic                     valid_x;
   exu_pkg::exu_op_e         op_x;
   logic                     pred_taken_x;
   logic [`EXU_PC_W-1:0]     pc_x;
   logic [`EXU_BR_IMM_W-1:0] br_immed_x;
   logic [`EXU_XLEN-1:0]     rs1_x;
   logic [`EXU_XLEN-1:0]     rs2_x;

   logic [`EXU_XLEN-1:0]     sum_x;
   logic [`EXU_XLEN-1:0]     diff_x;
   logic                     eq_x;
   logic                     lt_signed_x;
   logic                     lt_unsigned_x;
   logic [`EXU_PC_W-1:0]     pc_seq_x;
   logic [`EXU_PC_W-1:0]     pc_br_x;
   logic [`EXU_XLEN-1:0]     alu_result_x;
   logic                     taken_x;
   logic                     is_branch_x;
   logic                     legal_op_x;
   logic                     result_valid_x;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         valid_x <= 1'b0;
      end else begin
         valid_x <= i_d_pkt.valid & ~i_kill_d;  // Flushed D never reaches X
      end
   end

   // Payload follows the valid bit
   always_ff @(posedge clk) begin
      op_x         <= i_d_pkt.op;
      pred_taken_x <= i_d_pkt.pred_taken;
      pc_x         <= i_d_pkt.pc;
      br_immed_x   <= i_d_pkt.br_immed;
      rs1_x        <= i_rs1;
      rs2_x        <= i_rs2;
   end

   assign sum_x         = rs1_x + rs2_x;
   assign diff_x        = rs1_x - rs2_x;
   assign eq_x          = (rs1_x == rs2_x);
   assign lt_signed_x   = ($signed(rs1_x) < $signed(rs2_x));
   assign lt_unsigned_x = (rs1_x < rs2_x);

   // Halfword units, a 4-byte instruction is two
   assign pc_seq_x = pc_x + `EXU_PC_W'(2);
   assign pc_br_x  = pc_x + {{(`EXU_PC_W-`EXU_BR_IMM_W){br_immed_x[`EXU_BR_IMM_W-1]}},
                             br_immed_x};

   always_comb begin
      alu_result_x = '0;
      taken_x      = 1'b0;
      case (op_x)
         exu_pkg::ADD:  alu_result_x = sum_x;
         exu_pkg::SUB:  alu_result_x = diff_x;
         exu_pkg::AND:  alu_result_x = rs1_x & rs2_x;
         exu_pkg::OR:   alu_result_x = rs1_x | rs2_x;
         exu_pkg::XOR:  alu_result_x = rs1_x ^ rs2_x;
         exu_pkg::SLT:  alu_result_x = {{(`EXU_XLEN-1){1'b0}}, lt_signed_x};
         exu_pkg::SLTU: alu_result_x = {{(`EXU_XLEN-1){1'b0}}, lt_unsigned_x};
         exu_pkg::JAL:  alu_result_x = {pc_seq_x, 1'b0};  // Link address
         exu_pkg::BEQ:  taken_x      = eq_x;
         exu_pkg::BNE:  taken_x      = ~eq_x;
         exu_pkg::BLT:  taken_x      = lt_signed_x;
         exu_pkg::BGE:  taken_x      = ~lt_signed_x;
         default:       alu_result_x = '0;                // Unused encodings
      endcase
   end

   assign is_branch_x = exu_pkg::exu_is_branch(op_x);
   assign legal_op_x  = (op_x < `EXU_NUM_OPS);

   assign o_br_valid_x = valid_x & is_branch_x;
   assign o_br_taken_x = o_br_valid_x & taken_x;
   assign o_misp_x     = o_br_valid_x & (taken_x != pred_taken_x);
   assign o_target_x   = taken_x ? pc_br_x : pc_seq_x;

   // Branches write no register
   assign result_valid_x = valid_x & legal_op_x & ~is_branch_x;

   assign o_x_out.result_valid = result_valid_x;
   assign o_x_out.result       = result_valid_x ? alu_result_x : '0;
   assign o_x_out.pc           = result_valid_x ? pc_x : '0;

endmodule

//--- source/exu_core.sv
// Integer execute stage top with operand select, ALU, history and flush merge
`include "exu_defs.svh"

module exu_core (
   input  logic                     clk,
   input  logic                     i_reset,
   input  exu_pkg::exu_d_pkt_t      i_d_pkt,             // Instruction in D
   input  logic [`EXU_XLEN-1:0]     i_gpr_rs1,           // Register file data
   input  logic [`EXU_XLEN-1:0]     i_gpr_rs2,
   input  logic [`EXU_XLEN-1:0]     i_immed,             // Decoded immediate
   input  exu_pkg::exu_bypass_t     i_bypass,            // External bypass words
   input  logic                     i_flush_lower_r,     // Flush from a later stage
   input  logic [`EXU_PC_W-1:0]     i_flush_path_r,      // Its redirect target
   output exu_pkg::exu_x_out_t      o_x_out,
   output exu_pkg::exu_mp_pkt_t     o_mp_pkt,            // Mispredict report
   output logic [`EXU_GHR_SIZE-1:0] o_ghr_d,             // Speculative history
   output logic                     o_flush_final,       // Pipe flushed this cycle
   output logic [`EXU_PC_W-1:0]     o_flush_path_final   // Target of the oldest flush
);

   logic [`EXU_XLEN-1:0]     rs1_d;
   logic [`EXU_XLEN-1:0]     rs2_d;
   logic                     br_valid_x;
   logic                     br_taken_x;
   logic                     misp_x;
   logic [`EXU_PC_W-1:0]     target_x;
   logic [`EXU_GHR_SIZE-1:0] ghr_x;
   logic                     d_branch;
   logic                     x_commit;
   logic                     misp_upper;

   exu_operand_sel i_operand_sel (
      .i_src1     (i_d_pkt.src1),
      .i_src2     (i_d_pkt.src2),
      .i_gpr_rs1  (i_gpr_rs1),
      .i_gpr_rs2  (i_gpr_rs2),
      .i_pc       (i_d_pkt.pc),
      .i_immed    (i_immed),
      .i_bypass   (i_bypass),
      .i_result_x (o_x_out.result),
      .o_rs1      (rs1_d),
      .o_rs2      (rs2_d)
   );

   exu_alu_ctl i_alu_ctl (
      .clk          (clk),
      .i_reset      (i_reset),
      .i_d_pkt      (i_d_pkt),
      .i_rs1        (rs1_d),
      .i_rs2        (rs2_d),
      .i_kill_d     (o_flush_final),
      .o_x_out      (o_x_out),
      .o_br_valid_x (br_valid_x),
      .o_br_taken_x (br_taken_x),
      .o_misp_x     (misp_x),
      .o_target_x   (target_x)
   );

   assign d_branch   = i_d_pkt.valid & exu_pkg::exu_is_branch(i_d_pkt.op);
   assign x_commit   = br_valid_x & ~i_flush_lower_r;  // Older flush squashes X
   assign misp_upper = misp_x & ~i_flush_lower_r;

   exu_ghr i_ghr (
      .clk            (clk),
      .i_reset        (i_reset),
      .i_d_branch     (d_branch),
      .i_d_pred_taken (i_d_pkt.pred_taken),
      .i_x_branch     (x_commit),
      .i_x_taken      (br_taken_x),
      .i_flush        (o_flush_final),
      .o_ghr_d        (o_ghr_d),
      .o_ghr_x        (ghr_x)
   );

   assign o_flush_final      = i_flush_lower_r | misp_x;
   assign o_flush_path_final = ({`EXU_PC_W{i_flush_lower_r}} & i_flush_path_r) |
                               ({`EXU_PC_W{misp_upper}}      & target_x);

   always_comb begin
      o_mp_pkt = '0;
      if (misp_upper) begin
         o_mp_pkt.valid  = 1'b1;
         o_mp_pkt.ataken = br_taken_x;
         o_mp_pkt.target = target_x;
         o_mp_pkt.ghr    = ghr_x;  // Already holds this branch
      end
   end

endmodule

//--- source/exu_ghr.sv
// Global branch history with a speculative copy at D and a committed copy at X
`include "exu_defs.svh"

module exu_ghr (
   input  logic                     clk,
   input  logic                     i_reset,
   input  logic                     i_d_branch,      // Valid branch in D
   input  logic                     i_d_pred_taken,  // Predicted direction in D
   input  logic                     i_x_branch,      // Branch committing in X
   input  logic                     i_x_taken,       // Resolved direction in X
   input  logic                     i_flush,         // Pipe redirect this cycle
   output logic [`EXU_GHR_SIZE-1:0] o_ghr_d,         // Speculative history
   output logic [`EXU_GHR_SIZE-1:0] o_ghr_x          // Committed history with X update
);

   logic [`EXU_GHR_SIZE-1:0] ghr_d;
   logic [`EXU_GHR_SIZE-1:0] ghr_x;
   logic [`EXU_GHR_SIZE-1:0] ghr_x_ns;
   logic [`EXU_GHR_SIZE-1:0] ghr_d_ns;

   // Newest outcome enters at bit 0
   assign ghr_x_ns = i_x_branch ? {ghr_x[`EXU_GHR_SIZE-2:0], i_x_taken} : ghr_x;

   always_comb begin
      ghr_d_ns = ghr_d;
      if (i_flush) begin
         ghr_d_ns = ghr_x_ns;                                    // Repair speculation
      end else if (i_d_branch) begin
         ghr_d_ns = {ghr_d[`EXU_GHR_SIZE-2:0], i_d_pred_taken};
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         ghr_d <= '0;
         ghr_x <= '0;
      end else begin
         ghr_d <= ghr_d_ns;
         ghr_x <= ghr_x_ns;
      end
   end

   assign o_ghr_d = ghr_d;
   assign o_ghr_x = ghr_x_ns;  // Includes the branch now in X

endmodule

//--- source/exu_operand_sel.sv
// Operand select that picks bypass, register, PC or immediate for rs1 and rs2
`include "exu_defs.svh"

module exu_operand_sel (
   input  exu_pkg::exu_src_t    i_src1,      // rs1 select
   input  exu_pkg::exu_src_t    i_src2,      // rs2 select
   input  logic [`EXU_XLEN-1:0] i_gpr_rs1,   // Register file read data
   input  logic [`EXU_XLEN-1:0] i_gpr_rs2,
   input  logic [`EXU_PC_W-1:0] i_pc,        // D-stage PC in halfwords
   input  logic [`EXU_XLEN-1:0] i_immed,     // Decoded immediate
   input  exu_pkg::exu_bypass_t i_bypass,    // External bypass words
   input  logic [`EXU_XLEN-1:0] i_result_x,  // ALU result from X
   output logic [`EXU_XLEN-1:0] o_rs1,
   output logic [`EXU_XLEN-1:0] o_rs2
);

   logic [`EXU_NUM_BYPASS-1:0][`EXU_XLEN-1:0] bypass_words;
   logic [`EXU_XLEN-1:0]                      pc_word;

   // Bypass priority, then alternate source, then register, else zero
   function automatic logic [`EXU_XLEN-1:0] select_operand(
      input exu_pkg::exu_src_t                         src,
      input logic [`EXU_XLEN-1:0]                      gpr_word,
      input logic [`EXU_XLEN-1:0]                      alt_word,
      input logic [`EXU_NUM_BYPASS-1:0][`EXU_XLEN-1:0] byp_words
   );
      logic [`EXU_XLEN-1:0] byp_data;
      byp_data = '0;
      for (int i = 0; i < `EXU_NUM_BYPASS; i++) begin
         byp_data = byp_data | ({`EXU_XLEN{src.bypass_en[i]}} & byp_words[i]);
      end
      if (|src.bypass_en) begin
         return byp_data;
      end
      if (src.alt_en) begin
         return alt_word;
      end
      if (src.gpr_en) begin
         return gpr_word;
      end
      return '0;
   endfunction

   // Index matches the bypass_en bit order
   assign bypass_words[0] = i_bypass.result_r;
   assign bypass_words[1] = i_bypass.lsu_m;
   assign bypass_words[2] = i_result_x;       // Back-to-back dependency
   assign bypass_words[3] = i_bypass.nonblock;

   assign pc_word = {i_pc, 1'b0};             // Byte address for link and auipc forms

   assign o_rs1 = select_operand(i_src1, i_gpr_rs1, pc_word, bypass_words);
   assign o_rs2 = select_operand(i_src2, i_gpr_rs2, i_immed, bypass_words);

endmodule

//--- source/exu_pkg.sv
// Execute stage package with the op encoding and the packets between stages
`include "exu_defs.svh"

package exu_pkg;

   // Branches sit in the upper half of the encoding
   typedef enum logic [`EXU_OP_W-1:0] {
      ADD  = 4'd0,
      SUB  = 4'd1,
      AND  = 4'd2,
      OR   = 4'd3,
      XOR  = 4'd4,
      SLT  = 4'd5,
      SLTU = 4'd6,
      JAL  = 4'd7,
      BEQ  = 4'd8,
      BNE  = 4'd9,
      BLT  = 4'd10,
      BGE  = 4'd11
   } exu_op_e;

   typedef struct packed {
      logic                       gpr_en;     // Register file word
      logic [`EXU_NUM_BYPASS-1:0] bypass_en;  // One-hot result_r, lsu_m, result_x, nonblock
      logic                       alt_en;     // PC for rs1, immediate for rs2
   } exu_src_t;

   typedef struct packed {
      logic [`EXU_XLEN-1:0] result_r;  // Retire stage result
      logic [`EXU_XLEN-1:0] lsu_m;     // Load data in M
      logic [`EXU_XLEN-1:0] nonblock;  // Late load return
   } exu_bypass_t;

   typedef struct packed {
      logic                     valid;
      exu_op_e                  op;
      logic                     pred_taken;  // Predicted direction
      logic [`EXU_PC_W-1:0]     pc;          // Halfword address
      logic [`EXU_BR_IMM_W-1:0] br_immed;    // Signed halfword offset
      exu_src_t                 src1;
      exu_src_t                 src2;
   } exu_d_pkt_t;

   typedef struct packed {
      logic                     valid;
      logic                     ataken;  // Resolved direction
      logic [`EXU_PC_W-1:0]     target;  // Redirect address
      logic [`EXU_GHR_SIZE-1:0] ghr;     // History including this branch
   } exu_mp_pkt_t;

   typedef struct packed {
      logic                 result_valid;
      logic [`EXU_XLEN-1:0] result;
      logic [`EXU_PC_W-1:0] pc;
   } exu_x_out_t;

   // Conditional branches only, JAL writes a link and is not tracked
   function automatic logic exu_is_branch(input exu_op_e op);
      return op inside {BEQ, BNE, BLT, BGE};
   endfunction

endpackage
